/* include/cpu_subsys_defs.svh */
`ifndef CPU_SUBSYS_DEFS_SVH
`define CPU_SUBSYS_DEFS_SVH

// address phases that may run ahead of their data bursts
`define BURST_QUEUE_DEPTH 4

// write data bus width and its byte strobe
`define AXI_DATA_W 128
`define AXI_STRB_W 16

// fixed attributes of every write burst
`define AXI_BURST_INCR 2'b01
`define AXI_SIZE_16B 3'b100

`endif

/* hdl/cpu_subsys_pkg.sv */
`include "cpu_subsys_defs.svh"

package cpu_subsys_pkg;

  // byte address on the system bus
  typedef logic [39:0] axi_addr_t;

  // transaction id, shared by aw and the derived AXI3 wid
  typedef logic [7:0] axi_id_t;

  // beats in a burst minus one
  typedef logic [7:0] axi_len_t;

  // one full-width write beat
  typedef logic [`AXI_DATA_W-1:0] axi_data_t;

  // per-command data seed, one 32-bit lane of beat 0
  typedef logic [31:0] seed_t;

endpackage

/* hdl/wr_cmd_port.sv */
`timescale 1ns/1ps

module wr_cmd_port (
  input  logic                      pll_cpu_clk,
  input  logic                      pad_cpu_rst_b,
  input  logic                      cmd_req,
  input  cpu_subsys_pkg::axi_addr_t cmd_addr,
  input  cpu_subsys_pkg::axi_id_t   cmd_id,
  input  cpu_subsys_pkg::axi_len_t  cmd_len,
  input  cpu_subsys_pkg::seed_t     cmd_seed,
  output logic                      cmd_ack,
  output logic                      cmd_valid,
  input  logic                      cmd_ready,
  output cpu_subsys_pkg::axi_addr_t held_addr,
  output cpu_subsys_pkg::axi_id_t   held_id,
  output cpu_subsys_pkg::axi_len_t  held_len,
  output cpu_subsys_pkg::seed_t     held_seed
);

  typedef enum logic [1:0]
  {
    ST_IDLE,
    ST_OFFER,
    ST_ACKED
  } state_e;

  state_e state;
  state_e state_nxt;
  logic   capture;

  // a fresh request is only taken while idle, so ack is already low here
  assign capture = (state == ST_IDLE) && cmd_req;

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
      begin
        if (cmd_req)
          state_nxt = ST_OFFER;
      end
      ST_OFFER:
      begin
        if (cmd_ready)
          state_nxt = ST_ACKED; // engine took the command this cycle
      end
      ST_ACKED:
      begin
        if (!cmd_req)
          state_nxt = ST_IDLE; // requester has closed the handshake
      end
      default:
      begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge pll_cpu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  // request fields are stable while req is high, one sample is enough
  always_ff @(posedge pll_cpu_clk)
  begin
    if (capture)
    begin
      held_addr <= cmd_addr;
      held_id   <= cmd_id;
      held_len  <= cmd_len;
      held_seed <= cmd_seed;
    end
  end

  assign cmd_valid = (state == ST_OFFER);
  assign cmd_ack   = (state == ST_ACKED); // stays up until req is seen low

endmodule

/* hdl/axi_wr_engine.sv */
`timescale 1ns/1ps
`include "cpu_subsys_defs.svh"

module axi_wr_engine (
  input  logic                      pll_cpu_clk,
  input  logic                      pad_cpu_rst_b,
  input  logic                      cmd_valid,
  output logic                      cmd_ready,
  input  cpu_subsys_pkg::axi_addr_t held_addr,
  input  cpu_subsys_pkg::axi_id_t   held_id,
  input  cpu_subsys_pkg::axi_len_t  held_len,
  input  cpu_subsys_pkg::seed_t     held_seed,
  output cpu_subsys_pkg::axi_addr_t biu_pad_awaddr,
  output cpu_subsys_pkg::axi_id_t   biu_pad_awid,
  output cpu_subsys_pkg::axi_len_t  biu_pad_awlen,
  output logic [1:0]                biu_pad_awburst,
  output logic [2:0]                biu_pad_awsize,
  output logic                      biu_pad_awvalid,
  input  logic                      pad_biu_awready,
  output cpu_subsys_pkg::axi_data_t biu_pad_wdata,
  output logic [`AXI_STRB_W-1:0]    biu_pad_wstrb,
  output logic                      biu_pad_wlast,
  output logic                      biu_pad_wvalid,
  input  logic                      pad_biu_wready,
  output logic                      biu_pad_bready
);

  import cpu_subsys_pkg::*;

  localparam int DEPTH = `BURST_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  axi_len_t         len_q  [DEPTH];
  seed_t            seed_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] q_count;
  axi_len_t         beat_cnt;
  axi_len_t         next_beat;
  axi_len_t         head_len;
  seed_t            head_seed;
  logic             push;
  logic             pop;
  logic             w_hs;
  logic             head_ready;
  logic             w_start;
  logic             load_beat;

  // beat k carries seed + k in every 32-bit lane
  function automatic axi_data_t beat_data(seed_t seed, axi_len_t k);
    seed_t word;
    word = seed + seed_t'(k);
    return {(`AXI_DATA_W / 32){word}};
  endfunction

  // a new address may replace the current one only once it has handshaken
  assign cmd_ready = (q_count != CNT_W'(DEPTH)) && (!biu_pad_awvalid || pad_biu_awready);
  assign push      = cmd_valid && cmd_ready;

  assign w_hs = biu_pad_wvalid && pad_biu_wready;
  assign pop  = w_hs && biu_pad_wlast;

  assign head_len  = len_q[rd_ptr];
  assign head_seed = seed_q[rd_ptr];

  // Only the newest entry can still be waiting for its address handshake,
  // so the head is clear once there is an older entry or aw has gone idle
  assign head_ready = (q_count > CNT_W'(1)) || ((q_count == CNT_W'(1)) && !biu_pad_awvalid);

  assign w_start   = !biu_pad_wvalid && head_ready;
  assign load_beat = w_start || (w_hs && !biu_pad_wlast);
  assign next_beat = w_start ? '0 : axi_len_t'(beat_cnt + 1'b1);

  always_ff @(posedge pll_cpu_clk)
  begin
    if (push)
    begin
      len_q[wr_ptr]  <= held_len;
      seed_q[wr_ptr] <= held_seed;
    end
  end

  always_ff @(posedge pll_cpu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      q_count <= q_count + CNT_W'(push) - CNT_W'(pop); // push and pop may coincide
    end
  end

  always_ff @(posedge pll_cpu_clk)
  begin
    if (push)
    begin
      biu_pad_awaddr <= held_addr;
      biu_pad_awid   <= held_id;
      biu_pad_awlen  <= held_len;
    end
  end

  always_ff @(posedge pll_cpu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      biu_pad_awvalid <= 1'b0;
    else if (push)
      biu_pad_awvalid <= 1'b1;
    else if (pad_biu_awready)
      biu_pad_awvalid <= 1'b0; // address accepted by the slave
  end

  assign biu_pad_awburst = `AXI_BURST_INCR;
  assign biu_pad_awsize  = `AXI_SIZE_16B;

  always_ff @(posedge pll_cpu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      biu_pad_wvalid <= 1'b0;
      biu_pad_wlast  <= 1'b0;
      beat_cnt       <= '0;
    end
    else if (load_beat)
    begin
      biu_pad_wvalid <= 1'b1;
      biu_pad_wlast  <= (next_beat == head_len);
      beat_cnt       <= next_beat;
    end
    else if (pop)
    begin
      biu_pad_wvalid <= 1'b0; // one idle cycle before the next burst
      biu_pad_wlast  <= 1'b0;
    end
  end

  always_ff @(posedge pll_cpu_clk)
  begin
    if (load_beat)
      biu_pad_wdata <= beat_data(head_seed, next_beat);
  end

  assign biu_pad_wstrb = '1;

  // responses are simply drained once out of reset
  always_ff @(posedge pll_cpu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      biu_pad_bready <= 1'b0;
    else
      biu_pad_bready <= 1'b1;
  end

endmodule

/* hdl/wid_for_axi4.sv */
`timescale 1ns/1ps
`include "cpu_subsys_defs.svh"

module wid_for_axi4 (
  input  logic                    pll_cpu_clk,
  input  logic                    pad_cpu_rst_b,
  input  cpu_subsys_pkg::axi_id_t biu_pad_awid,
  input  logic                    biu_pad_awvalid,
  input  logic                    pad_biu_awready,
  input  logic                    biu_pad_wvalid,
  input  logic                    pad_biu_wready,
  input  logic                    biu_pad_wlast,
  output cpu_subsys_pkg::axi_id_t biu_pad_wid
);

  import cpu_subsys_pkg::*;

  localparam int DEPTH = `BURST_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  axi_id_t          id_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] id_count;
  logic             push;
  logic             pop;

  // ids enter in address order and leave as each burst's last beat passes
  assign push = biu_pad_awvalid && pad_biu_awready;
  assign pop  = biu_pad_wvalid && pad_biu_wready && biu_pad_wlast;

  always_ff @(posedge pll_cpu_clk)
  begin
    if (push)
      id_q[wr_ptr] <= biu_pad_awid;
  end

  always_ff @(posedge pll_cpu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      id_count <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)
        id_count <= id_count + 1'b1;
      else if (pop && !push)
        id_count <= id_count - 1'b1; // simultaneous push and pop leave it unchanged
    end
  end

  // An empty queue has nothing meaningful to show, so hold wid at zero
  // rather than exposing a stale slot
  assign biu_pad_wid = (id_count != '0) ? id_q[rd_ptr] : '0;

endmodule

/* hdl/cpu_subsystem.sv */
`timescale 1ns/1ps
`include "cpu_subsys_defs.svh"

module cpu_subsystem (
  input  logic                      pll_cpu_clk,
  input  logic                      pad_cpu_rst_b,
  input  logic                      cmd_req,
  output logic                      cmd_ack,
  input  cpu_subsys_pkg::axi_addr_t cmd_addr,
  input  cpu_subsys_pkg::axi_id_t   cmd_id,
  input  cpu_subsys_pkg::axi_len_t  cmd_len,
  input  cpu_subsys_pkg::seed_t     cmd_seed,
  output cpu_subsys_pkg::axi_addr_t biu_pad_awaddr,
  output cpu_subsys_pkg::axi_id_t   biu_pad_awid,
  output cpu_subsys_pkg::axi_len_t  biu_pad_awlen,
  output logic [1:0]                biu_pad_awburst,
  output logic [2:0]                biu_pad_awsize,
  output logic                      biu_pad_awvalid,
  input  logic                      pad_biu_awready,
  output cpu_subsys_pkg::axi_data_t biu_pad_wdata,
  output logic [`AXI_STRB_W-1:0]    biu_pad_wstrb,
  output logic                      biu_pad_wlast,
  output logic                      biu_pad_wvalid,
  input  logic                      pad_biu_wready,
  output logic                      biu_pad_bready,
  output cpu_subsys_pkg::axi_id_t   biu_pad_wid
);

  import cpu_subsys_pkg::*;

  logic      cmd_valid;
  logic      cmd_ready;
  axi_addr_t held_addr;
  axi_id_t   held_id;
  axi_len_t  held_len;
  seed_t     held_seed;

  // stands in for the core's bus interface unit
  wr_cmd_port wr_cmd_port_i (
    .pll_cpu_clk   (pll_cpu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .cmd_req       (cmd_req),
    .cmd_addr      (cmd_addr),
    .cmd_id        (cmd_id),
    .cmd_len       (cmd_len),
    .cmd_seed      (cmd_seed),
    .cmd_ack       (cmd_ack),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .held_addr     (held_addr),
    .held_id       (held_id),
    .held_len      (held_len),
    .held_seed     (held_seed)
  );

  axi_wr_engine axi_wr_engine_i (
    .pll_cpu_clk     (pll_cpu_clk),
    .pad_cpu_rst_b   (pad_cpu_rst_b),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .held_addr       (held_addr),
    .held_id         (held_id),
    .held_len        (held_len),
    .held_seed       (held_seed),
    .biu_pad_awaddr  (biu_pad_awaddr),
    .biu_pad_awid    (biu_pad_awid),
    .biu_pad_awlen   (biu_pad_awlen),
    .biu_pad_awburst (biu_pad_awburst),
    .biu_pad_awsize  (biu_pad_awsize),
    .biu_pad_awvalid (biu_pad_awvalid),
    .pad_biu_awready (pad_biu_awready),
    .biu_pad_wdata   (biu_pad_wdata),
    .biu_pad_wstrb   (biu_pad_wstrb),
    .biu_pad_wlast   (biu_pad_wlast),
    .biu_pad_wvalid  (biu_pad_wvalid),
    .pad_biu_wready  (pad_biu_wready),
    .biu_pad_bready  (biu_pad_bready)
  );

  // derives the AXI3 wid from the AXI4-style write traffic on the pins
  wid_for_axi4 wid_for_axi4_i (
    .pll_cpu_clk     (pll_cpu_clk),
    .pad_cpu_rst_b   (pad_cpu_rst_b),
    .biu_pad_awid    (biu_pad_awid),
    .biu_pad_awvalid (biu_pad_awvalid),
    .pad_biu_awready (pad_biu_awready),
    .biu_pad_wvalid  (biu_pad_wvalid),
    .pad_biu_wready  (pad_biu_wready),
    .biu_pad_wlast   (biu_pad_wlast),
    .biu_pad_wid     (biu_pad_wid)
  );

endmodule

/* sim/tb_cpu_subsystem.sv */
`timescale 1ns/1ps
`include "cpu_subsys_defs.svh"

module tb_cpu_subsystem;

  import cpu_subsys_pkg::*;

  localparam int NUM_RANDOM = 40;
  localparam int PAT_LEN    = 1024;

  logic                    pll_cpu_clk;
  logic                    pad_cpu_rst_b;
  logic                    cmd_req;
  logic                    cmd_ack;
  axi_addr_t               cmd_addr;
  axi_id_t                 cmd_id;
  axi_len_t                cmd_len;
  seed_t                   cmd_seed;
  axi_addr_t               biu_pad_awaddr;
  axi_id_t                 biu_pad_awid;
  axi_len_t                biu_pad_awlen;
  logic [1:0]              biu_pad_awburst;
  logic [2:0]              biu_pad_awsize;
  logic                    biu_pad_awvalid;
  logic                    pad_biu_awready;
  axi_data_t               biu_pad_wdata;
  logic [`AXI_STRB_W-1:0]  biu_pad_wstrb;
  logic                    biu_pad_wlast;
  logic                    biu_pad_wvalid;
  logic                    pad_biu_wready;
  logic                    biu_pad_bready;
  axi_id_t                 biu_pad_wid;

  int   errors       = 0;
  int   tests_failed = 0;
  int   cycles       = 0;
  int   cycle_limit  = 2000;
  int   cmds_sent    = 0;
  int   aws_checked  = 0;
  int   bursts_done  = 0;
  int   beat_idx     = 0;
  int   ready_idx    = 0;
  logic aw_random    = 1'b0;
  logic w_random     = 1'b0;
  logic w_stall      = 1'b0;
  logic prev_ack     = 1'b0;
  logic prev_req     = 1'b0;
  logic prev_rst_b   = 1'b0;
  logic aw_pat [PAT_LEN];
  logic w_pat  [PAT_LEN];

  axi_addr_t exp_addr [$]; // commands in request order, waiting for their address phase
  axi_id_t   exp_id   [$];
  axi_len_t  exp_len  [$];
  seed_t     exp_seed [$];
  axi_id_t   bq_id    [$]; // bursts whose address went out, waiting for their data
  axi_len_t  bq_len   [$];
  seed_t     bq_seed  [$];

  axi_addr_t              obs_awaddr  [$];
  axi_id_t                obs_awid    [$];
  axi_len_t               obs_awlen   [$];
  logic [1:0]             obs_awburst [$];
  logic [2:0]             obs_awsize  [$];
  axi_data_t              obs_wdata   [$];
  logic [`AXI_STRB_W-1:0] obs_wstrb   [$];
  logic                   obs_wlast   [$];
  axi_id_t                obs_wid     [$];

  axi_addr_t rnd_addr [NUM_RANDOM];
  axi_id_t   rnd_id   [NUM_RANDOM];
  axi_len_t  rnd_len  [NUM_RANDOM];
  seed_t     rnd_seed [NUM_RANDOM];

  cpu_subsystem cpu_subsystem_i (.*);

  // every 32-bit lane of beat k holds seed plus k
  function automatic axi_data_t expected_beat(seed_t seed, int k);
    axi_data_t data;
    for (int lane = 0; lane < `AXI_DATA_W / 32; lane++)
      data[lane*32 +: 32] = seed + seed_t'(k);
    return data;
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    assert (got === exp)
    else
    begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_reset_outputs();
    check_value("cmd_ack", cmd_ack, 1'b0);
    check_value("biu_pad_awvalid", biu_pad_awvalid, 1'b0);
    check_value("biu_pad_wvalid", biu_pad_wvalid, 1'b0);
    check_value("biu_pad_wlast", biu_pad_wlast, 1'b0);
  endtask

  task automatic raise_request(input axi_addr_t addr, input axi_id_t id,
                               input axi_len_t len, input seed_t seed);
    exp_addr.push_back(addr);
    exp_id.push_back(id);
    exp_len.push_back(len);
    exp_seed.push_back(seed);
    cmds_sent++;
    @(posedge pll_cpu_clk);
    cmd_addr <= addr;
    cmd_id   <= id;
    cmd_len  <= len;
    cmd_seed <= seed;
    cmd_req  <= 1'b1;
  endtask

  task automatic wait_ack(input logic level);
    do
      @(negedge pll_cpu_clk);
    while (cmd_ack !== level);
  endtask

  task automatic close_request();
    @(posedge pll_cpu_clk);
    cmd_req <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic send_command(input axi_addr_t addr, input axi_id_t id,
                              input axi_len_t len, input seed_t seed);
    raise_request(addr, id, len, seed);
    wait_ack(1'b1);
    close_request();
  endtask

  task automatic wait_drained();
    while (bursts_done != cmds_sent)
      @(negedge pll_cpu_clk);
    repeat (10) @(negedge pll_cpu_clk); // room for a stray extra address phase
    assert (aws_checked == cmds_sent)
    else
    begin
      $display("%0d address phases seen for %0d commands", aws_checked, cmds_sent);
      errors++;
    end
  endtask

  task automatic finish_test(input int num, input string name, input int err_mark);
    if (errors > err_mark)
    begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", num, name, errors - err_mark);
    end
    else
      $display("test %0d %s: passed", num, name);
  endtask

  initial
  begin
    pll_cpu_clk = 1'b0;
    forever #2 pll_cpu_clk = ~pll_cpu_clk;
  end

  initial
  begin
    while (cycles < cycle_limit)
    begin
      @(posedge pll_cpu_clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Finished with errors");
    $finish;
  end

  // bus slave ready lines follow a pattern drawn once at the start
  always @(posedge pll_cpu_clk)
  begin
    pad_biu_awready <= aw_random ? aw_pat[ready_idx] : 1'b1;
    pad_biu_wready  <= w_stall ? 1'b0 : (w_random ? w_pat[ready_idx] : 1'b1);
    ready_idx = (ready_idx + 1) % PAT_LEN;
  end

  always @(negedge pll_cpu_clk)
  begin
    if (pad_cpu_rst_b)
    begin
      if (prev_rst_b)
        check_value("biu_pad_bready", biu_pad_bready, 1'b1); // up from the first edge out of reset
      if (biu_pad_awvalid && pad_biu_awready)
      begin
        obs_awaddr.push_back(biu_pad_awaddr);
        obs_awid.push_back(biu_pad_awid);
        obs_awlen.push_back(biu_pad_awlen);
        obs_awburst.push_back(biu_pad_awburst);
        obs_awsize.push_back(biu_pad_awsize);
      end
      if (biu_pad_wvalid && pad_biu_wready)
      begin
        obs_wdata.push_back(biu_pad_wdata);
        obs_wstrb.push_back(biu_pad_wstrb);
        obs_wlast.push_back(biu_pad_wlast);
        obs_wid.push_back(biu_pad_wid);
      end
      if (prev_ack && !cmd_ack)
        assert (!prev_req)
        else
        begin
          $display("cmd_ack fell while cmd_req was still high");
          errors++;
        end
    end
    prev_ack   = cmd_ack;
    prev_req   = cmd_req;
    prev_rst_b = pad_cpu_rst_b;
  end

  always @(posedge pll_cpu_clk)
  begin
    while (obs_awaddr.size() > 0)
    begin
      assert (exp_addr.size() > 0)
      else
      begin
        $display("an address phase appeared with no outstanding command");
        errors++;
      end
      if (exp_addr.size() > 0)
      begin
        check_value("biu_pad_awaddr", obs_awaddr[0], exp_addr[0]);
        check_value("biu_pad_awid", obs_awid[0], exp_id[0]);
        check_value("biu_pad_awlen", obs_awlen[0], exp_len[0]);
        check_value("biu_pad_awburst", obs_awburst[0], `AXI_BURST_INCR);
        check_value("biu_pad_awsize", obs_awsize[0], `AXI_SIZE_16B);
        bq_id.push_back(exp_id.pop_front());
        bq_len.push_back(exp_len.pop_front());
        bq_seed.push_back(exp_seed.pop_front());
        void'(exp_addr.pop_front());
      end
      aws_checked++;
      void'(obs_awaddr.pop_front());
      void'(obs_awid.pop_front());
      void'(obs_awlen.pop_front());
      void'(obs_awburst.pop_front());
      void'(obs_awsize.pop_front());
    end
    while (obs_wdata.size() > 0)
    begin
      assert (bq_id.size() > 0)
      else
      begin
        $display("a data beat arrived before the address phase of its burst");
        errors++;
      end
      if (bq_id.size() > 0)
      begin
        check_value("biu_pad_wdata", obs_wdata[0], expected_beat(bq_seed[0], beat_idx));
        check_value("biu_pad_wstrb", obs_wstrb[0], {`AXI_STRB_W{1'b1}});
        check_value("biu_pad_wlast", obs_wlast[0], beat_idx == int'(bq_len[0]));
        check_value("biu_pad_wid", obs_wid[0], bq_id[0]);
        if (beat_idx == int'(bq_len[0]))
        begin
          void'(bq_id.pop_front());
          void'(bq_len.pop_front());
          void'(bq_seed.pop_front());
          beat_idx = 0;
          bursts_done++;
        end
        else
          beat_idx++;
      end
      void'(obs_wdata.pop_front());
      void'(obs_wstrb.pop_front());
      void'(obs_wlast.pop_front());
      void'(obs_wid.pop_front());
    end
  end

  initial
  begin
    int err_mark;
    int total_beats;
    void'($urandom(17209));
    pad_cpu_rst_b   = 1'b0;
    cmd_req         = 1'b0;
    cmd_addr        = '0;
    cmd_id          = '0;
    cmd_len         = '0;
    cmd_seed        = '0;
    pad_biu_awready = 1'b0;
    pad_biu_wready  = 1'b0;
    for (int i = 0; i < PAT_LEN; i++)
    begin
      aw_pat[i] = ($urandom % 2) == 1;
      w_pat[i]  = ($urandom % 4) != 0;
    end
    total_beats = 4 + 2 + (`BURST_QUEUE_DEPTH + 1) * 3; // fixed tests 2 to 4
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      rnd_addr[i] = axi_addr_t'({$urandom, $urandom}) & ~axi_addr_t'(15);
      rnd_id[i]   = axi_id_t'($urandom);
      rnd_len[i]  = axi_len_t'($urandom % 8);
      rnd_seed[i] = $urandom;
      total_beats += int'(rnd_len[i]) + 1;
    end
    cycle_limit = total_beats * 8 + 2000;

    err_mark = errors;
    repeat (4)
    begin
      @(negedge pll_cpu_clk);
      check_reset_outputs();
    end
    @(posedge pll_cpu_clk);
    pad_cpu_rst_b <= 1'b1;
    repeat (2)
    begin
      @(negedge pll_cpu_clk);
      check_reset_outputs();
    end
    finish_test(1, "reset values", err_mark);

    err_mark = errors;
    send_command(40'h00_1000_0040, 8'h5a, 8'd3, 32'h1234_0000);
    wait_drained();
    finish_test(2, "single burst", err_mark);

    err_mark = errors;
    raise_request(40'h00_2000_0100, 8'h21, 8'd1, 32'hcafe_0010);
    wait_ack(1'b1);
    repeat (3)
    begin
      @(negedge pll_cpu_clk);
      assert (cmd_ack)
      else
      begin
        $display("cmd_ack fell while cmd_req was held high");
        errors++;
      end
    end
    close_request();
    wait_drained();
    finish_test(3, "four-phase handshake", err_mark);

    err_mark = errors;
    w_stall = 1'b1; // data channel blocked so the burst queue fills
    for (int i = 0; i < `BURST_QUEUE_DEPTH; i++)
      send_command(40'h00_3000_0000 + 40'(i * 256), 8'h40 + 8'(i), 8'd2,
                   32'h0bad_0000 + 32'(i * 16));
    raise_request(40'h00_3000_1000, 8'h4f, 8'd2, 32'h0bad_1000);
    repeat (20)
    begin
      @(negedge pll_cpu_clk);
      assert (!cmd_ack)
      else
      begin
        $display("cmd_ack rose although the burst queue was full");
        errors++;
      end
    end
    w_stall = 1'b0;
    wait_ack(1'b1);
    close_request();
    wait_drained();
    finish_test(4, "full queue and wid order", err_mark);

    err_mark = errors;
    aw_random = 1'b1;
    w_random  = 1'b1;
    for (int i = 0; i < NUM_RANDOM; i++)
      send_command(rnd_addr[i], rnd_id[i], rnd_len[i], rnd_seed[i]);
    wait_drained();
    aw_random = 1'b0;
    w_random  = 1'b0;
    finish_test(5, "random commands under back-pressure", err_mark);

    $display("tests run 5, tests failed %0d, errors %0d", tests_failed, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

/* sim.f */
+incdir+include
hdl/cpu_subsys_pkg.sv
hdl/wr_cmd_port.sv
hdl/axi_wr_engine.sv
hdl/wid_for_axi4.sv
hdl/cpu_subsystem.sv
sim/tb_cpu_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

TOP=tb_cpu_subsystem
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module "$TOP" --Mdir obj_dir -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
  echo "simulation reported failures, see $LOG"
  exit 1
fi

echo "simulation passed"
exit 0
